/* compile.f */
+incdir+verif
hdl/gmt_pkg.sv
hdl/credit_fifo.sv
hdl/centroid_unit.sv
hdl/coeff_gen.sv
hdl/point_transformer.sv
hdl/gmt_unit_top.sv
verif/gmt_tb.sv

/* hdl/centroid_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module centroid_unit (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire gmt_pkg::obj_t obj_in,
    output gmt_pkg::point_t [3:0] rel_pts,
    output gmt_pkg::point_t    centroid,
    output logic               valid
);

    import gmt_pkg::*;

    logic signed [17:0] sum_x;  // room for four 16-bit terms
    logic signed [17:0] sum_y;
    point_t             cen_nxt;

    // all four slots count, whatever the object type
    always_comb begin
        sum_x = '0;
        sum_y = '0;
        for (int i = 0; i < 4; i++) begin
            sum_x = sum_x + obj_in.pts[i].x;
            sum_y = sum_y + obj_in.pts[i].y;
        end
        cen_nxt.x = coord_t'(sum_x >>> 2);
        cen_nxt.y = coord_t'(sum_y >>> 2);
    end

    always_ff @(posedge clk) begin
        if (start) begin
            centroid <= cen_nxt;
            for (int i = 0; i < 4; i++) begin
                rel_pts[i].x <= obj_in.pts[i].x - cen_nxt.x;  // wraps at 16 bits
                rel_pts[i].y <= obj_in.pts[i].y - cen_nxt.y;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (start) begin
            valid <= 1'b1;  // stays up until next command
        end
    end

endmodule

`default_nettype wire

/* hdl/coeff_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_gen (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             start,
    input  wire gmt_pkg::gmt_op_t op,
    input  wire logic [3:0]       code,
    input  wire gmt_pkg::coord_t  amount,
    output gmt_pkg::coeff_t       coeff,
    output logic                  valid
);

    import gmt_pkg::*;

    coeff_t     coeff_nxt;
    logic [2:0] angle;
    logic [1:0] ratio;

    assign angle = code[2:0];
    assign ratio = code[1:0];

    always_comb begin
        coeff_nxt = '0;
        case (op)
            OP_TRANS_ALL, OP_TRANS_ONE: begin
                coeff_nxt.m11 = 16'sd1;  // identity, offsets do the work
                coeff_nxt.m22 = 16'sd1;
                coeff_nxt.dx  = code[0] ? amount : '0;
                coeff_nxt.dy  = code[1] ? amount : '0;
            end
            OP_SCALE: begin
                coeff_nxt.m11     = SCALE_NUM[ratio];
                coeff_nxt.m22     = SCALE_NUM[ratio];
                coeff_nxt.shift   = SCALE_SHIFT[ratio];
                coeff_nxt.use_cen = 1'b1;
            end
            OP_ROT_L: begin
                coeff_nxt.m11     = ROT_COS[angle];
                coeff_nxt.m12     = -ROT_SIN[angle];
                coeff_nxt.m21     = ROT_SIN[angle];
                coeff_nxt.m22     = ROT_COS[angle];
                coeff_nxt.shift   = ROT_SHIFT;
                coeff_nxt.use_cen = 1'b1;
            end
            OP_ROT_R: begin
                // mirror of left, sin terms flipped
                coeff_nxt.m11     = ROT_COS[angle];
                coeff_nxt.m12     = ROT_SIN[angle];
                coeff_nxt.m21     = -ROT_SIN[angle];
                coeff_nxt.m22     = ROT_COS[angle];
                coeff_nxt.shift   = ROT_SHIFT;
                coeff_nxt.use_cen = 1'b1;
            end
            default: coeff_nxt = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            coeff <= coeff_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (start) begin
            valid <= 1'b1;
        end
    end

    // command source must only queue known ops
    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> op inside {OP_TRANS_ALL, OP_TRANS_ONE, OP_SCALE, OP_ROT_L, OP_ROT_R});

endmodule

`default_nettype wire

/* hdl/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire payload_t din,
    input  wire logic     pop,
    output payload_t      dout,
    output logic          empty,
    output logic          credit
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];  // head always visible

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CW'(push) - CW'(pop);
            credit <= pop;  // one slot freed, hand it back
        end
    end

    // sender must hold a credit for every push
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

/* hdl/gmt_pkg.sv */
`default_nettype none

package gmt_pkg;

    typedef logic signed [15:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // value doubles as index of last valid point
    typedef enum logic [1:0] {
        OBJ_POINT = 2'd0,
        OBJ_LINE  = 2'd1,
        OBJ_TRI   = 2'd2,
        OBJ_QUAD  = 2'd3
    } obj_type_t;

    typedef struct packed {
        point_t [3:0] pts;
        logic [7:0]   color;
        obj_type_t    kind;
    } obj_t;

    typedef enum logic [2:0] {
        OP_TRANS_ALL = 3'd0,
        OP_TRANS_ONE = 3'd1,
        OP_SCALE     = 3'd2,
        OP_ROT_L     = 3'd3,
        OP_ROT_R     = 3'd4
    } gmt_op_t;

    typedef struct packed {
        gmt_op_t    op;
        logic [3:0] code;    // point select in 3:2, axis/ratio/angle below
        coord_t     amount;  // translate offset
        obj_t       obj;
    } gmt_cmd_t;

    // x' = (m11*x + m12*y) >>> shift + dx, same for y
    typedef struct packed {
        coord_t     m11;
        coord_t     m12;
        coord_t     m21;
        coord_t     m22;
        coord_t     dx;
        coord_t     dy;
        logic [3:0] shift;
        logic       use_cen;
    } coeff_t;

    // q1.15, angle k*45 deg, unit magnitude clipped to 32767
    localparam coord_t ROT_COS [8] = '{16'sd32767, 16'sd23170, 16'sd0, -16'sd23170,
                                       -16'sd32767, -16'sd23170, 16'sd0, 16'sd23170};
    localparam coord_t ROT_SIN [8] = '{16'sd0, 16'sd23170, 16'sd32767, 16'sd23170,
                                       16'sd0, -16'sd23170, -16'sd32767, -16'sd23170};

    // ratios 1/2, 3/4, 3/2, 2/1
    localparam coord_t     SCALE_NUM   [4] = '{16'sd1, 16'sd3, 16'sd3, 16'sd2};
    localparam logic [3:0] SCALE_SHIFT [4] = '{4'd1, 4'd2, 4'd1, 4'd0};

    localparam logic [3:0] ROT_SHIFT = 4'd15;

endpackage

`default_nettype wire

/* hdl/gmt_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gmt_unit_top #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              cmd_valid,
    input  wire gmt_pkg::gmt_cmd_t cmd,
    output logic                   cmd_credit,
    output logic                   obj_valid,
    output gmt_pkg::obj_t          obj_out,
    input  wire logic              obj_credit
);

    import gmt_pkg::*;

    gmt_cmd_t     fifo_cmd;  // head of queue
    logic         fifo_empty;
    logic         take;
    point_t [3:0] rel_pts;
    point_t       centroid;
    logic         cen_valid;
    coeff_t       coeff;
    logic         coeff_valid;

    credit_fifo #(
        .DEPTH     (IN_DEPTH),
        .payload_t (gmt_cmd_t)
    ) i_cmd_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .push   (cmd_valid),
        .din    (cmd),
        .pop    (take),
        .dout   (fifo_cmd),
        .empty  (fifo_empty),
        .credit (cmd_credit)
    );

    // both side units start on the same pop
    centroid_unit i_centroid (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (take),
        .obj_in   (fifo_cmd.obj),
        .rel_pts  (rel_pts),
        .centroid (centroid),
        .valid    (cen_valid)
    );

    coeff_gen i_coeff (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (take),
        .op     (fifo_cmd.op),
        .code   (fifo_cmd.code),
        .amount (fifo_cmd.amount),
        .coeff  (coeff),
        .valid  (coeff_valid)
    );

    point_transformer #(
        .OUT_CREDITS (OUT_CREDITS)
    ) i_xform (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo_empty  (fifo_empty),
        .take        (take),
        .cmd         (fifo_cmd),
        .rel_pts     (rel_pts),
        .centroid    (centroid),
        .cen_valid   (cen_valid),
        .coeff       (coeff),
        .coeff_valid (coeff_valid),
        .obj_valid   (obj_valid),
        .obj_out     (obj_out),
        .obj_credit  (obj_credit)
    );

endmodule

`default_nettype wire

/* hdl/point_transformer.sv */
`timescale 1ns/1ps
`default_nettype none

module point_transformer #(
    parameter int OUT_CREDITS = 2
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  fifo_empty,
    output logic                       take,
    input  wire gmt_pkg::gmt_cmd_t     cmd,
    input  wire gmt_pkg::point_t [3:0] rel_pts,
    input  wire gmt_pkg::point_t       centroid,
    input  wire logic                  cen_valid,
    input  wire gmt_pkg::coeff_t       coeff,
    input  wire logic                  coeff_valid,
    output logic                       obj_valid,
    output gmt_pkg::obj_t              obj_out,
    input  wire logic                  obj_credit
);

    import gmt_pkg::*;

    localparam int CW = $clog2(OUT_CREDITS + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT,
        ST_LOAD,
        ST_MULT,
        ST_SHIFT_ADD,
        ST_WRITEBACK
    } state_t;

    state_t             state;
    state_t             state_nxt;
    logic [CW-1:0]      credit_cnt;
    logic [1:0]         pt_cnt;
    logic               last_pt;
    logic               upd_pt;
    gmt_cmd_t           cmd_r;
    point_t [3:0]       res_pts;
    coord_t             cur_x;
    coord_t             cur_y;
    logic signed [31:0] p11;
    logic signed [31:0] p12;
    logic signed [31:0] p21;
    logic signed [31:0] p22;
    logic signed [31:0] sum_x;
    logic signed [31:0] sum_y;
    coord_t             new_x;
    coord_t             new_y;

    // a credit is reserved at take, so a result never lacks one
    assign take    = (state == ST_IDLE) && !fifo_empty && (credit_cnt != '0);
    assign last_pt = (pt_cnt == cmd_r.obj.kind);
    assign upd_pt  = (cmd_r.op != OP_TRANS_ONE) || (cmd_r.code[3:2] == pt_cnt);

    assign sum_x = (p11 + p12) >>> coeff.shift;
    assign sum_y = (p21 + p22) >>> coeff.shift;

    always_comb begin
        new_x = coord_t'(sum_x) + coeff.dx;  // low 16 bits only
        new_y = coord_t'(sum_y) + coeff.dy;
        if (coeff.use_cen) begin
            new_x = new_x + centroid.x;  // back to absolute coords
            new_y = new_y + centroid.y;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:      if (take) state_nxt = ST_WAIT;
            ST_WAIT:      if (cen_valid && coeff_valid) state_nxt = ST_LOAD;
            ST_LOAD:      state_nxt = ST_MULT;
            ST_MULT:      state_nxt = ST_SHIFT_ADD;
            ST_SHIFT_ADD: state_nxt = last_pt ? ST_WRITEBACK : ST_LOAD;
            ST_WRITEBACK: state_nxt = ST_IDLE;
            default:      state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            pt_cnt    <= '0;
            obj_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            obj_valid <= (state == ST_WRITEBACK);
            if (take) begin
                pt_cnt <= '0;
            end else if (state == ST_SHIFT_ADD) begin
                pt_cnt <= pt_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CW'(OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt + CW'(obj_credit) - CW'(take);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd_r   <= cmd;
            res_pts <= cmd.obj.pts;  // untouched points pass through
        end
        if (state == ST_LOAD) begin
            if (coeff.use_cen) begin
                cur_x <= rel_pts[pt_cnt].x;
                cur_y <= rel_pts[pt_cnt].y;
            end else begin
                cur_x <= cmd_r.obj.pts[pt_cnt].x;
                cur_y <= cmd_r.obj.pts[pt_cnt].y;
            end
        end
        if (state == ST_MULT) begin
            p11 <= cur_x * coeff.m11;
            p12 <= cur_y * coeff.m12;
            p21 <= cur_x * coeff.m21;
            p22 <= cur_y * coeff.m22;
        end
        if ((state == ST_SHIFT_ADD) && upd_pt) begin
            res_pts[pt_cnt].x <= new_x;
            res_pts[pt_cnt].y <= new_y;
        end
        if (state == ST_WRITEBACK) begin
            obj_out.pts   <= res_pts;
            obj_out.color <= cmd_r.obj.color;
            obj_out.kind  <= cmd_r.obj.kind;
        end
    end

    // count stays between zero and its reset value, a wrap lands above it
    a_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= CW'(OUT_CREDITS));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and decide pass or fail from the printed summary
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module gmt_tb -o gmt_tb_sim \
    && ./obj_dir/gmt_tb_sim | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/gmt_tb_model.svh */
`ifndef GMT_TB_MODEL_SVH
`define GMT_TB_MODEL_SVH

// mean of all four slots, rounded toward minus infinity
function automatic point_t model_centroid(obj_t o);
    int     sx;
    int     sy;
    point_t c;
    sx = 0;
    sy = 0;
    for (int i = 0; i < 4; i++) begin
        sx += int'(o.pts[i].x);
        sy += int'(o.pts[i].y);
    end
    c.x = coord_t'(sx >>> 2);
    c.y = coord_t'(sy >>> 2);
    return c;
endfunction

// expected object for one command
function automatic obj_t model_transform(gmt_cmd_t c);
    obj_t   r;
    point_t cen;
    coord_t m11, m12, m21, m22;
    coord_t dx, dy;
    coord_t rx, ry;
    coord_t nx, ny;
    int     sx, sy;
    int     sh;
    bit     cen_on;
    r      = c.obj;
    cen    = model_centroid(c.obj);
    m11    = 16'sd1;
    m12    = '0;
    m21    = '0;
    m22    = 16'sd1;
    dx     = '0;
    dy     = '0;
    sh     = 0;
    cen_on = 1'b0;
    case (c.op)
        OP_TRANS_ALL, OP_TRANS_ONE: begin
            dx = c.code[0] ? c.amount : 16'sd0;
            dy = c.code[1] ? c.amount : 16'sd0;
        end
        OP_SCALE: begin
            m11    = SCALE_NUM[c.code[1:0]];
            m22    = SCALE_NUM[c.code[1:0]];
            sh     = int'(SCALE_SHIFT[c.code[1:0]]);
            cen_on = 1'b1;
        end
        OP_ROT_L, OP_ROT_R: begin
            m11    = ROT_COS[c.code[2:0]];
            m22    = ROT_COS[c.code[2:0]];
            m12    = (c.op == OP_ROT_L) ? -ROT_SIN[c.code[2:0]] : ROT_SIN[c.code[2:0]];
            m21    = (c.op == OP_ROT_L) ? ROT_SIN[c.code[2:0]] : -ROT_SIN[c.code[2:0]];
            sh     = 15;
            cen_on = 1'b1;
        end
        default: ;
    endcase
    for (int i = 0; i <= int'(c.obj.kind); i++) begin
        if (c.op != OP_TRANS_ONE || int'(c.code[3:2]) == i) begin
            rx = c.obj.pts[i].x;
            ry = c.obj.pts[i].y;
            if (cen_on) begin
                rx = rx - cen.x;  // 16-bit wrap
                ry = ry - cen.y;
            end
            sx = (int'(rx) * int'(m11) + int'(ry) * int'(m12)) >>> sh;
            sy = (int'(rx) * int'(m21) + int'(ry) * int'(m22)) >>> sh;
            nx = coord_t'(sx) + dx;
            ny = coord_t'(sy) + dy;
            if (cen_on) begin
                nx = nx + cen.x;
                ny = ny + cen.y;
            end
            r.pts[i].x = nx;
            r.pts[i].y = ny;
        end
    end
    return r;
endfunction

`endif

/* verif/gmt_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module gmt_tb;

    import gmt_pkg::*;

    localparam int IN_DEPTH    = 4;
    localparam int OUT_CREDITS = 2;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    gmt_cmd_t cmd;
    logic     cmd_credit;
    logic     obj_valid;
    obj_t     obj_out;
    logic     obj_credit;

    integer   seed = 32'ha883e9d1;
    int       issued;         // commands handed to the DUT
    int       n_cmd_credits;  // cmd_credit pulses seen
    int       n_results;
    int       n_returned;     // obj_credit pulses given back
    int       n_checked;
    int       cycle;
    int       credit_delay;
    bit       hold_credit;
    int       errors;
    int       proto_errors;
    obj_t     exp_q [$];
    obj_t     got_q [$];
    int       due_q [$];      // cycle at which each result's credit goes back

    `include "gmt_tb_model.svh"

    gmt_unit_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .obj_valid  (obj_valid),
        .obj_out    (obj_out),
        .obj_credit (obj_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (obj_valid) begin
                got_q.push_back(obj_out);
                due_q.push_back(cycle + credit_delay);
                n_results++;
                assert (n_results <= OUT_CREDITS + n_returned) else begin
                    proto_errors++;
                    $display("obj_valid at %0t came without an output credit", $time);
                end
            end
            if (cmd_credit) begin
                n_cmd_credits++;
            end
        end
    end

    // credit receiver, one obj_credit pulse per cycle at most
    initial begin
        obj_credit = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (rst_n && !hold_credit && n_returned < due_q.size()
                    && due_q[n_returned] <= cycle) begin
                obj_credit <= 1'b1;
                n_returned++;
            end else begin
                obj_credit <= 1'b0;
            end
        end
    end

    // budget grows with every command sent
    initial begin
        int wd_cycles;
        wd_cycles = 0;
        while (wd_cycles <= 200 * (issued + 1)) begin
            @(negedge clk);
            wd_cycles++;
        end
        $display("timeout: DUT stopped making progress after %0d commands", issued);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic coord_t rand_coord();
        return coord_t'($random(seed) % 4096);
    endfunction

    function automatic obj_t rand_obj(obj_type_t kind);
        obj_t o;
        for (int i = 0; i < 4; i++) begin
            o.pts[i].x = rand_coord();
            o.pts[i].y = rand_coord();
        end
        o.color = 8'($random(seed));
        o.kind  = kind;
        return o;
    endfunction

    function automatic gmt_cmd_t make_cmd(gmt_op_t op, logic [3:0] code, coord_t amount,
                                          obj_t obj);
        return '{op, code, amount, obj};
    endfunction

    function automatic bit within_one(obj_t a, obj_t b);
        int d;
        for (int i = 0; i < 4; i++) begin
            d = int'(a.pts[i].x) - int'(b.pts[i].x);
            if (d > 1 || d < -1) return 1'b0;
            d = int'(a.pts[i].y) - int'(b.pts[i].y);
            if (d > 1 || d < -1) return 1'b0;
        end
        return (a.color == b.color) && (a.kind == b.kind);
    endfunction

    // waits for a credit, then presents the command for one cycle
    task automatic send_cmd(gmt_cmd_t c);
        while (IN_DEPTH - issued + n_cmd_credits <= 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        issued++;
        exp_q.push_back(model_transform(c));
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // in-order compare of everything outstanding, then drain credits
    task automatic check_results(string name);
        obj_t got;
        obj_t exp;
        while (got_q.size() < exp_q.size()) begin
            @(negedge clk);
        end
        while (n_checked < exp_q.size()) begin
            got = got_q[n_checked];
            exp = exp_q[n_checked];
            assert (got == exp) else begin
                errors++;
                $display("Fail at %0t: %s result %0d is %h, expected %h",
                         $time, name, n_checked, got, exp);
            end
            n_checked++;
        end
        while (n_returned < due_q.size()) begin
            @(negedge clk);
        end
    endtask

    task automatic test_translate_all();
        obj_t o;
        for (int t = 0; t < 2; t++) begin
            o = rand_obj(t == 0 ? OBJ_QUAD : OBJ_LINE);
            for (int axis = 1; axis < 4; axis++) begin  // x, y, both
                send_cmd(make_cmd(OP_TRANS_ALL, 4'(axis), rand_coord(), o));
            end
        end
        check_results("translate all");
    endtask

    task automatic test_translate_one();
        obj_t o;
        int   base;
        o    = rand_obj(OBJ_QUAD);
        base = issued;
        for (int sel = 0; sel < 4; sel++) begin
            send_cmd(make_cmd(OP_TRANS_ONE, {2'(sel), 2'b11}, coord_t'(100 + sel), o));
        end
        check_results("translate one");
        for (int sel = 0; sel < 4; sel++) begin
            for (int j = 0; j < 4; j++) begin
                if (j != sel) begin
                    assert (got_q[base + sel].pts[j] == o.pts[j]) else begin
                        errors++;
                        $display("Fail at %0t: translate one moved point %0d, select %0d",
                                 $time, j, sel);
                    end
                end
            end
        end
    endtask

    task automatic test_scale();
        for (int r = 0; r < 4; r++) begin
            for (int n = 0; n < 2; n++) begin
                send_cmd(make_cmd(OP_SCALE, 4'(r), '0, rand_obj(OBJ_TRI)));
            end
        end
        check_results("scale");
    endtask

    task automatic test_rotate();
        obj_t o;
        obj_t zero_in [$];
        int   zero_idx [$];
        for (int dir = 0; dir < 2; dir++) begin
            for (int k = 0; k < 8; k++) begin
                o = rand_obj(OBJ_QUAD);
                if (k == 0) begin
                    zero_in.push_back(o);
                    zero_idx.push_back(issued);
                end
                send_cmd(make_cmd(dir == 0 ? OP_ROT_L : OP_ROT_R, 4'(k), '0, o));
            end
        end
        check_results("rotate");
        foreach (zero_idx[i]) begin
            assert (within_one(got_q[zero_idx[i]], zero_in[i])) else begin
                errors++;
                $display("Fail at %0t: rotation by 0 moved a point by more than 1", $time);
            end
        end
    endtask

    task automatic test_back_pressure();
        int base;
        int credits_seen;
        base         = issued;
        credits_seen = 0;
        hold_credit  = 1'b1;
        fork
            begin
                for (int n = 0; n < 8; n++) begin
                    send_cmd(make_cmd(gmt_op_t'(n % 5), 4'(n), 16'sd37,
                                      rand_obj(obj_type_t'(n % 4))));
                end
            end
            begin
                // two in the transformer, four in the FIFO, sender out of credits
                while (issued < base + 6 || IN_DEPTH - issued + n_cmd_credits > 0) begin
                    @(negedge clk);
                end
                credits_seen = n_cmd_credits;
                repeat (20) @(negedge clk);
                assert (n_cmd_credits == credits_seen && issued == base + 6) else begin
                    errors++;
                    $display("cmd_credit kept flowing while output credits were withheld");
                end
                hold_credit = 1'b0;
            end
        join
        check_results("back-pressure");
        assert (n_cmd_credits > credits_seen) else begin
            errors++;
            $display("cmd_credit never resumed after output credits came back");
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        hold_credit  = 1'b0;
        credit_delay = 1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_translate_all();
        test_translate_one();
        credit_delay = 3;
        test_scale();
        test_rotate();
        credit_delay = 2;
        test_back_pressure();
        repeat (5) @(negedge clk);
        assert (got_q.size() == exp_q.size()) else begin
            errors++;
            $display("DUT produced %0d results for %0d commands", got_q.size(), exp_q.size());
        end
        $display("checked %0d results, %0d mismatches, %0d protocol errors",
                 n_checked, errors, proto_errors);
        if (errors + proto_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
